//--- files.f
+incdir+common
common/calc_pkg.sv
exec/int_alu.sv
exec/mul_pipe.sv
logic/operand_bypass.sv
logic/issue_reg.sv
logic/completion_pipe.sv
logic/calc_top.sv
verif/clk_gen.sv
verif/calc_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = calc_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/calc_tb.sv
`default_nettype none

module calc_tb;

  import calc_pkg::*;

  // One dispatch slot whose register data comes from the stale file when driven
  typedef struct packed {
    int        test_id;
    logic      v;
    alu_op_e   op;
    reg_addr_t rd_addr;
    logic      rd_w_v;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      flush;
  } slot_s;

  typedef struct packed {
    logic [31:0] slot_no;
    slot_s       s;
  } pend_s;

  logic          clk;
  logic          rst_n;
  dispatch_pkt_s dispatch;
  logic          flush;
  wb_pkt_s       wb;

  data_t       stale_rf [32];
  data_t       arch_rf [32];
  slot_s       slots [$];
  pend_s       pending [$];
  wb_pkt_s     expected [$];
  wb_pkt_s     exp_wb;
  logic [31:0] slot_no = '0;
  integer      seed = 49;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  int          checks = 0;
  int          pushed = 0;
  int          popped = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_names [6] = '{"reset_idle", "alu_independent", "alu_chain",
                                  "mul_mix", "zero_reg", "flush"};

  clk_gen #(.period(10)) u_clk (.clk_o(clk));

  calc_top DUT
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.dispatch_i(dispatch)
     ,.flush_i(flush)
     ,.wb_o(wb)
     );

  // Architectural result of one instruction
  // Mul keeps only the low word
  function automatic data_t ref_result(alu_op_e op, data_t a, data_t b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_mul:  return a * b;
      default: return '0;
    endcase
  endfunction

  task automatic add_slot(input int id, input logic v, input alu_op_e op, input int rd,
                          input int rs1, input int rs2, input logic w, input logic fl);
    slot_s s;
    s = '{test_id: id, v: v, op: op, rd_addr: reg_addr_t'(rd), rd_w_v: w,
          rs1_addr: reg_addr_t'(rs1), rs2_addr: reg_addr_t'(rs2), flush: fl};
    slots.push_back(s);
  endtask

  task automatic add_op(input int id, input alu_op_e op, input int rd, input int rs1,
                        input int rs2);
    add_slot(id, 1'b1, op, rd, rs1, rs2, 1'b1, 1'b0);
  endtask

  task automatic add_idle(input int id, input logic fl);
    add_slot(id, 1'b0, op_add, 0, 0, 0, 1'b0, fl);
  endtask

  // Enough empty slots for the last instruction to leave the pipe
  task automatic add_drain(input int id);
    repeat (4) add_idle(id, 1'b0);
  endtask

  task automatic build_tests();
    // Slots without v but with live fields must stay silent
    repeat (4) add_slot(0, 1'b0, op_add, 1, 9, 10, 1'b1, 1'b0);
    repeat (4) add_slot(0, 1'b0, op_mul, 2, 11, 12, 1'b1, 1'b0);
    add_drain(0);
    add_op(1, op_add, 1, 9, 10);
    add_op(1, op_sub, 2, 11, 12);
    add_op(1, op_and, 3, 13, 14);
    add_op(1, op_or, 4, 15, 16);
    add_op(1, op_xor, 5, 17, 18);
    add_op(1, op_sll, 6, 19, 20);
    add_op(1, op_srl, 7, 21, 22);
    add_op(1, op_slt, 8, 23, 24);
    add_drain(1);
    // Distances 1 to 5 back to x1 and then three x1 writers in flight at once
    add_op(2, op_add, 1, 9, 10);
    add_op(2, op_add, 2, 1, 11);
    add_op(2, op_sub, 3, 1, 2);
    add_op(2, op_xor, 4, 1, 3);
    add_op(2, op_or, 5, 1, 4);
    add_op(2, op_add, 6, 1, 5);
    add_op(2, op_add, 1, 1, 13);
    add_op(2, op_add, 1, 1, 14);
    add_op(2, op_xor, 1, 1, 15);
    add_op(2, op_slt, 7, 1, 2);
    add_op(2, op_srl, 8, 1, 7);
    add_drain(2);
    add_op(3, op_mul, 1, 9, 10);
    add_op(3, op_mul, 2, 11, 12);
    add_op(3, op_add, 3, 13, 14);
    add_op(3, op_mul, 4, 1, 15);
    add_op(3, op_add, 5, 2, 3);
    add_op(3, op_xor, 6, 1, 5);
    add_op(3, op_mul, 7, 5, 6);
    add_idle(3, 1'b0);
    add_idle(3, 1'b0);
    add_op(3, op_add, 8, 4, 7);
    add_op(3, op_mul, 9, 8, 8);
    add_op(3, op_mul, 10, 3, 3);
    add_op(3, op_mul, 11, 12, 13);
    add_op(3, op_add, 11, 14, 15);
    add_op(3, op_sub, 12, 11, 1);
    add_drain(3);
    add_op(4, op_add, 0, 9, 10);
    add_op(4, op_add, 1, 0, 11);
    add_slot(4, 1'b1, op_or, 2, 9, 10, 1'b0, 1'b0);
    add_op(4, op_add, 3, 2, 0);
    add_op(4, op_mul, 0, 9, 9);
    add_op(4, op_slt, 4, 0, 9);
    add_drain(4);
    // Flush on the fifth slot keeps only the first and the idle flush later drops three more
    add_op(5, op_add, 1, 9, 10);
    add_op(5, op_add, 2, 1, 11);
    add_op(5, op_mul, 3, 9, 10);
    add_op(5, op_add, 1, 1, 12);
    add_slot(5, 1'b1, op_sub, 4, 1, 2, 1'b1, 1'b1);
    add_op(5, op_add, 5, 1, 2);
    add_op(5, op_xor, 6, 3, 4);
    add_op(5, op_mul, 7, 5, 6);
    add_idle(5, 1'b1);
    add_op(5, op_add, 8, 5, 7);
    add_drain(5);
  endtask

  task automatic retire(input pend_s p);
    data_t   res;
    wb_pkt_s pkt;
    res = ref_result(p.s.op, arch_rf[p.s.rs1_addr], arch_rf[p.s.rs2_addr]);
    if (p.s.rd_w_v && p.s.rd_addr != '0)
      begin
        arch_rf[p.s.rd_addr] = res;
        pkt = '{v: 1'b1, rd_addr: p.s.rd_addr, data: res};
        expected.push_back(pkt);
        pushed++;
      end
  endtask

  task automatic drive_slot(input slot_s s);
    dispatch_pkt_s pkt;
    pend_s         p;
    pkt = '{v: s.v, op: s.op, rd_addr: s.rd_addr, rd_w_v: s.rd_w_v,
            rs1_addr: s.rs1_addr, rs2_addr: s.rs2_addr,
            rs1: stale_rf[s.rs1_addr], rs2: stale_rf[s.rs2_addr]};
    dispatch <= pkt;
    flush    <= s.flush;
    if (s.v)
      begin
        p = '{slot_no: slot_no, s: s};
        pending.push_back(p);
      end
    // Only the last four slots are still open to a flush
    if (s.flush)
      begin
        pending.delete();
      end
    while (pending.size() > 0 && pending[0].slot_no + 32'd3 <= slot_no)
      begin
        retire(pending.pop_front());
      end
    slot_no++;
  endtask

  task automatic finish_test(input int id);
    int failed;
    assert (expected.size() == 0 && popped == pushed)
      else
        begin
          $display("Test %0d: %0d writebacks were expected but %0d came out", id, pushed,
                   popped);
          errors++;
        end
    failed = (errors != errors_at_start);
    $display("Test %0d %s: %s, %0d writebacks", id, test_names[id], failed ? "FAIL" : "pass",
             popped);
    tests_run++;
    if (failed)
      begin
        tests_failed++;
      end
    expected.delete();
    pushed          = 0;
    popped          = 0;
    errors_at_start = errors;
  endtask

  always @(negedge clk)
    begin
      if (rst_n && wb.v)
        begin
          popped++;
          assert (expected.size() > 0)
            else
              begin
                $display("Unexpected writeback to x%0d at time %0t, nothing was due",
                         wb.rd_addr, $time);
                errors++;
              end
          if (expected.size() > 0)
            begin
              exp_wb = expected.pop_front();
              checks++;
              assert (wb == exp_wb)
                else
                  begin
                    $display("CHECK FAILED at time %0t: wb x%0d = %h, expected x%0d = %h",
                             $time, wb.rd_addr, wb.data, exp_wb.rd_addr, exp_wb.data);
                    errors++;
                  end
            end
          if (wb.rd_addr != '0)
            begin
              stale_rf[wb.rd_addr] = wb.data;
            end
        end
    end

  always @(posedge clk)
    begin
      cycles++;
      if (cycle_limit != 0 && cycles >= cycle_limit)
        begin
          $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
          $display("Some tests failed");
          $finish;
        end
    end

  initial
    begin
      int prev_id;
      rst_n    = 1'b0;
      flush    = 1'b0;
      dispatch = '0;
      for (int i = 0; i < 32; i++)
        begin
          stale_rf[i] = (i == 0) ? '0 : $random(seed);
          arch_rf[i]  = stale_rf[i];
        end
      build_tests();
      cycle_limit = 10 + slots.size() + 50;
      repeat (10) @(posedge clk);
      rst_n   <= 1'b1;
      prev_id = 0;
      foreach (slots[i])
        begin
          @(posedge clk);
          if (slots[i].test_id != prev_id)
            begin
              finish_test(prev_id);
              prev_id = slots[i].test_id;
            end
          drive_slot(slots[i]);
        end
      @(posedge clk);
      finish_test(prev_id);
      $display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
               checks, errors);
      if (errors == 0)
        begin
          $display("All tests passed");
        end
      else
        begin
          $display("Some tests failed");
        end
      $finish;
    end

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
`default_nettype none

module clk_gen
  #(parameter int period = 10)
  (output logic clk_o
   );

  initial
    begin
      clk_o = 1'b0;
      forever
        begin
          #(period/2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- logic/calc_top.sv
`default_nettype none

`include "calc_consts.svh"

module calc_top
  (input  logic                    clk_i
   , input  logic                  rst_n_i
   , input  calc_pkg::dispatch_pkt_s dispatch_i
   , input  logic                  flush_i
   , output calc_pkg::wb_pkt_s     wb_o
   );

  import calc_pkg::*;

  stage_tag_s [`CALC_STAGES-1:0]  stage_tags;
  data_t      [`CALC_STAGES-1:0]  fwd_data;
  reg_addr_t  [`CALC_SRC_OPS-1:0] src_addr;
  data_t      [`CALC_SRC_OPS-1:0] rf_data;
  data_t      [`CALC_SRC_OPS-1:0] rs_data;
  reservation_s                   reservation;
  stage_tag_s                     issue_tag;
  logic                           int_v;
  data_t                          int_data;
  logic                           mul_v;
  data_t                          mul_data;

  assign src_addr = {dispatch_i.rs2_addr, dispatch_i.rs1_addr};
  assign rf_data  = {dispatch_i.rs2, dispatch_i.rs1};

  for (genvar i = 0; i < `CALC_SRC_OPS; i++)
    begin : bypass
      operand_bypass u_bypass
        (.src_addr_i(src_addr[i])
         ,.rf_data_i(rf_data[i])
         ,.stage_tags_i(stage_tags)
         ,.fwd_data_i(fwd_data)
         ,.data_o(rs_data[i])
         );
    end

  issue_reg u_issue
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dispatch_i(dispatch_i)
     ,.rs_data_i(rs_data)
     ,.reservation_o(reservation)
     ,.issue_tag_o(issue_tag)
     );

  // 1 cycle latency
  int_alu u_alu
    (.reservation_i(reservation)
     ,.v_o(int_v)
     ,.data_o(int_data)
     );

  // 3 cycle latency
  mul_pipe u_mul
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.reservation_i(reservation)
     ,.v_o(mul_v)
     ,.data_o(mul_data)
     );

  completion_pipe u_comp
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.flush_i(flush_i)
     ,.issue_tag_i(issue_tag)
     ,.int_v_i(int_v)
     ,.int_data_i(int_data)
     ,.mul_v_i(mul_v)
     ,.mul_data_i(mul_data)
     ,.stage_tags_o(stage_tags)
     ,.fwd_data_o(fwd_data)
     ,.wb_o(wb_o)
     );

endmodule

`default_nettype wire

//--- logic/completion_pipe.sv
`default_nettype none

`include "calc_consts.svh"

module completion_pipe
  (input  logic                                      clk_i
   , input  logic                                    rst_n_i
   , input  logic                                    flush_i
   , input  calc_pkg::stage_tag_s                    issue_tag_i
   , input  logic                                    int_v_i
   , input  calc_pkg::data_t                         int_data_i
   , input  logic                                    mul_v_i
   , input  calc_pkg::data_t                         mul_data_i
   , output calc_pkg::stage_tag_s [`CALC_STAGES-1:0] stage_tags_o
   , output calc_pkg::data_t [`CALC_STAGES-1:0]      fwd_data_o
   , output calc_pkg::wb_pkt_s                       wb_o
   );

  import calc_pkg::*;

  stage_tag_s [`CALC_STAGES-1:0] tag_n;
  stage_tag_s [`CALC_STAGES-1:0] tag_r;
  // No result is ready in stage 0, so data starts at stage 1
  data_t      [`CALC_STAGES-1:1] data_n;
  data_t      [`CALC_STAGES-1:1] data_r;

  // Shift down the pipe and merge results at their fixed stage
  // Single issue with static latencies means merges never collide
  always_comb
    begin
      tag_n[0] = issue_tag_i;
      for (int i = 1; i < `CALC_STAGES; i++)
        begin
          tag_n[i] = tag_r[i-1];
        end

      data_n[1] = '0;
      for (int i = 2; i < `CALC_STAGES; i++)
        begin
          data_n[i] = data_r[i-1];
        end

      data_n[`CALC_INT_STAGE] |= int_v_i ? int_data_i : '0;
      data_n[`CALC_MUL_STAGE] |= mul_v_i ? mul_data_i : '0;

      // Flush kills everything short of writeback
      for (int i = 0; i < `CALC_STAGES; i++)
        begin
          tag_n[i].w_v &= ~flush_i;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          for (int i = 0; i < `CALC_STAGES; i++)
            begin
              tag_r[i].w_v <= 1'b0;
            end
        end
      else
        begin
          tag_r  <= tag_n;
          data_r <= data_n;
        end
    end

  for (genvar i = 0; i < `CALC_STAGES; i++)
    begin : fwd
      assign stage_tags_o[i] = tag_r[i];
      // Forward what is about to land in the next stage
      if (i < `CALC_STAGES-1)
        begin : next_stage
          assign fwd_data_o[i] = data_n[i+1];
        end
      else
        begin : last_stage
          assign fwd_data_o[i] = data_r[i];
        end
    end

  assign wb_o = '{v: tag_r[`CALC_STAGES-1].w_v, rd_addr: tag_r[`CALC_STAGES-1].rd_addr,
                  data: data_r[`CALC_STAGES-1]};

endmodule

`default_nettype wire

//--- logic/issue_reg.sv
`default_nettype none

`include "calc_consts.svh"

module issue_reg
  (input  logic                                     clk_i
   , input  logic                                   rst_n_i
   , input  calc_pkg::dispatch_pkt_s                dispatch_i
   , input  calc_pkg::data_t [`CALC_SRC_OPS-1:0]     rs_data_i
   , output calc_pkg::reservation_s                 reservation_o
   , output calc_pkg::stage_tag_s                   issue_tag_o
   );

  import calc_pkg::*;

  logic    v_r;
  alu_op_e op_r;
  data_t   rs1_r;
  data_t   rs2_r;

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          v_r <= 1'b0;
        end
      else
        begin
          v_r <= dispatch_i.v;
        end
    end

  // Operands already carry the bypassed values
  always_ff @(posedge clk_i)
    begin
      op_r  <= dispatch_i.op;
      rs1_r <= rs_data_i[0];
      rs2_r <= rs_data_i[1];
    end

  assign reservation_o = '{v: v_r, op: op_r, rs1: rs1_r, rs2: rs2_r};

  // Tag that enters completion stage 0 on the same edge
  assign issue_tag_o.w_v     = dispatch_i.v && dispatch_i.rd_w_v && (dispatch_i.rd_addr != '0);
  assign issue_tag_o.rd_addr = dispatch_i.rd_addr;

endmodule

`default_nettype wire

//--- logic/operand_bypass.sv
`default_nettype none

`include "calc_consts.svh"

module operand_bypass
  (input  calc_pkg::reg_addr_t                      src_addr_i
   , input  calc_pkg::data_t                        rf_data_i
   , input  calc_pkg::stage_tag_s [`CALC_STAGES-1:0] stage_tags_i
   , input  calc_pkg::data_t [`CALC_STAGES-1:0]      fwd_data_i
   , output calc_pkg::data_t                        data_o
   );

  logic [`CALC_STAGES-1:0] match;

  // Stages never hold w_v for x0, so x0 always reads the register file
  for (genvar i = 0; i < `CALC_STAGES; i++)
    begin : stage_match
      assign match[i] = stage_tags_i[i].w_v
                        && (stage_tags_i[i].rd_addr == src_addr_i);
    end

  // Walk from oldest to youngest so the lowest matching stage wins
  always_comb
    begin
      data_o = rf_data_i;
      for (int i = `CALC_STAGES-1; i >= 0; i--)
        begin
          if (match[i])
            begin
              data_o = fwd_data_i[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- exec/mul_pipe.sv
`default_nettype none

`include "calc_consts.svh"

module mul_pipe
  (input  logic                   clk_i
   , input  logic                 rst_n_i
   , input  calc_pkg::reservation_s reservation_i
   , output logic                 v_o
   , output calc_pkg::data_t      data_o
   );

  import calc_pkg::*;

  localparam int half = `CALC_XLEN/2;

  logic            v1_r;
  logic            v2_r;
  data_t           part_lo_r;
  logic [half-1:0] part_hi_r;
  data_t           prod_r;

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          v1_r <= 1'b0;
          v2_r <= 1'b0;
        end
      else
        begin
          v1_r <= reservation_i.v && (reservation_i.op == op_mul);
          v2_r <= v1_r;
        end
    end

  // First cycle splits rs2 into halves, the upper half only matters below bit 32
  always_ff @(posedge clk_i)
    begin
      part_lo_r <= reservation_i.rs1 * data_t'(reservation_i.rs2[half-1:0]);
      part_hi_r <= reservation_i.rs1[half-1:0] * reservation_i.rs2[`CALC_XLEN-1:half];
      prod_r    <= part_lo_r + {part_hi_r, {half{1'b0}}};
    end

  assign v_o    = v2_r;
  assign data_o = prod_r;

endmodule

`default_nettype wire

//--- exec/int_alu.sv
`default_nettype none

`include "calc_consts.svh"

module int_alu
  (input  calc_pkg::reservation_s reservation_i
   , output logic                 v_o
   , output calc_pkg::data_t      data_o
   );

  import calc_pkg::*;

  localparam int shamt_w = $clog2(`CALC_XLEN);

  data_t              a;
  data_t              b;
  logic [shamt_w-1:0] shamt;

  assign a     = reservation_i.rs1;
  assign b     = reservation_i.rs2;
  assign shamt = b[shamt_w-1:0];

  always_comb
    begin
      case (reservation_i.op)
        op_add:  data_o = a + b;
        op_sub:  data_o = a - b;
        op_and:  data_o = a & b;
        op_or:   data_o = a | b;
        op_xor:  data_o = a ^ b;
        op_sll:  data_o = a << shamt;
        op_srl:  data_o = a >> shamt;
        op_slt:  data_o = data_t'($signed(a) < $signed(b));
        default: data_o = '0;
      endcase
    end

  // Multiplies belong to the other pipe
  assign v_o = reservation_i.v && (reservation_i.op != op_mul);

endmodule

`default_nettype wire

//--- common/calc_pkg.sv
`default_nettype none

`include "calc_consts.svh"

package calc_pkg;

  typedef logic [`CALC_XLEN-1:0] data_t;
  typedef logic [`CALC_REG_ADDR_W-1:0] reg_addr_t;

  // Decoded opcode, mul is the only one not run by the ALU
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt,
    op_mul
  } alu_op_e;

  // Source values may be stale, the bypass fixes them up
  typedef struct packed {
    logic      v;
    alu_op_e   op;
    reg_addr_t rd_addr;
    logic      rd_w_v;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1;
    data_t     rs2;
  } dispatch_pkt_s;

  typedef struct packed {
    logic    v;
    alu_op_e op;
    data_t   rs1;
    data_t   rs2;
  } reservation_s;

  typedef struct packed {
    logic      w_v;
    reg_addr_t rd_addr;
  } stage_tag_s;

  typedef struct packed {
    logic      v;
    reg_addr_t rd_addr;
    data_t     data;
  } wb_pkt_s;

endpackage

`default_nettype wire

//--- common/calc_consts.svh
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// Datapath and register file
`define CALC_XLEN 32
`define CALC_REG_ADDR_W 5

// Completion pipe depth, stages numbered 0 to 3
`define CALC_STAGES 4

// Stage that each execute pipe merges its result into
`define CALC_INT_STAGE 1
`define CALC_MUL_STAGE 3

// rs1 and rs2
`define CALC_SRC_OPS 2

`endif
